// File: hdl/sdram_pkg.sv
//----------------------------------------------------------
// DDR4 controller shared types and constants
// Address map, latencies, request/response and command encodings
//----------------------------------------------------------
package sdram_pkg;

    // Address and data geometry
    localparam int PADDR_BITS     = 16;
    localparam int COL_BITS       = 4;
    localparam int ROW_BITS       = 8;
    localparam int BG_BITS        = 2;
    localparam int BA_BITS        = 2;
    localparam int NUM_BANKS      = 2 ** (BG_BITS + BA_BITS);
    localparam int DATA_BITS      = 64;
    localparam int DRAM_ADDR_BITS = 17;             // A16..A0 on the DIMM

    // DIMM timing, in controller cycles
    localparam int CAS_LATENCY        = 22;         // READ on pins to data on dq
    localparam int ACTIVATION_LATENCY = 8;          // ACTIVATE to READ/WRITE
    localparam int PRECHARGE_LATENCY  = 5;          // PRECHARGE to ACTIVATE
    localparam int WAIT_BITS = $clog2((ACTIVATION_LATENCY > PRECHARGE_LATENCY) ?
                                      ACTIVATION_LATENCY : PRECHARGE_LATENCY);

    typedef logic [BG_BITS+BA_BITS-1:0] bank_id_t;  // Bank group in the high bits
    typedef logic [ROW_BITS-1:0]        row_t;
    typedef logic [COL_BITS-1:0]        col_t;

    typedef struct packed {
        logic [PADDR_BITS-1:0] addr;
        logic                  write;               // High for a store
        logic [DATA_BITS-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic [PADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]  rdata;
    } mem_rsp_t;

    // Codes 0..3 follow the command CLB numbering
    typedef enum logic [2:0] {
        READ      = 3'd0,
        WRITE     = 3'd1,
        ACTIVATE  = 3'd2,
        PRECHARGE = 3'd3,
        NOP       = 3'd4
    } dram_cmd_e;

    typedef enum logic [1:0] {CLOSED, OPENING, OPEN, CLOSING} bank_state_e;

    typedef enum logic {DISP_IDLE, DISP_ACK} dispatch_state_e;

    typedef struct packed {
        dram_cmd_e            cmd;
        row_t                 row;
        col_t                 col;
        logic [DATA_BITS-1:0] wdata;
    } bank_cmd_t;

    typedef struct packed {
        logic                      act_n;           // Low marks an ACTIVATE
        logic [DRAM_ADDR_BITS-1:0] dram_addr;
        logic [BG_BITS-1:0]        bg;
        logic [BA_BITS-1:0]        ba;
    } dram_pins_t;

    //----------------------------------------------------------
    // Address map helpers: row | bg | ba | col
    //----------------------------------------------------------
    function automatic bank_id_t addr_bank(logic [PADDR_BITS-1:0] addr);
        return addr[COL_BITS +: BG_BITS+BA_BITS];
    endfunction

    function automatic row_t addr_row(logic [PADDR_BITS-1:0] addr);
        return addr[PADDR_BITS-1 -: ROW_BITS];
    endfunction

    function automatic col_t addr_col(logic [PADDR_BITS-1:0] addr);
        return addr[COL_BITS-1:0];
    endfunction

    function automatic logic [PADDR_BITS-1:0] make_addr(bank_id_t bank, row_t row, col_t col);
        return {row, bank, col};
    endfunction

endpackage : sdram_pkg

// File: hdl/request_dispatch.sv
//----------------------------------------------------------
// Request intake: four-phase handshake, bank decode and load
//----------------------------------------------------------
module request_dispatch import sdram_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_N_in,
    input  logic                 mem_req_valid,
    input  mem_req_t             mem_req,
    output logic                 mem_req_ack,
    input  logic [NUM_BANKS-1:0] bank_busy,
    output logic [NUM_BANKS-1:0] bank_load,
    output mem_req_t             bank_req
);

    dispatch_state_e state;
    bank_id_t        target;                        // Bank addressed by the request
    logic            take;                          // Hand the request over this cycle

    assign target   = addr_bank(mem_req.addr);
    assign take     = (state == DISP_IDLE) && mem_req_valid && !bank_busy[target];
    assign bank_req = mem_req;                      // Shared bus, only the loaded bank latches

    // One-hot load strobe, lasts a single cycle since the FSM leaves IDLE
    always_comb begin
        bank_load = '0;
        if (take) begin
            bank_load[target] = 1'b1;
        end
    end

    //----------------------------------------------------------
    // Handshake FSM, ack is the registered ACK state
    //----------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state <= DISP_IDLE;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (take) state <= DISP_ACK;    // Busy bank holds us here
                end
                DISP_ACK: begin
                    if (!mem_req_valid) state <= DISP_IDLE;  // Requester finished phase 3
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    assign mem_req_ack = (state == DISP_ACK);

    // Requester must hold the request until it sees ack
    a_req_stable: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        (mem_req_valid && !mem_req_ack) ##1 (mem_req_valid && !mem_req_ack)
        |-> $stable(mem_req));

endmodule : request_dispatch

// File: hdl/bank_machine.sv
//----------------------------------------------------------
// Bank machine: open-page row tracking and timed commands
//----------------------------------------------------------
module bank_machine import sdram_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_N_in,
    input  logic      load,
    input  mem_req_t  req,
    output logic      busy,
    output logic      cmd_pending,
    output bank_cmd_t cmd,
    input  logic      grant
);

    bank_state_e          state;
    mem_req_t             req_q;                    // Request being served
    row_t                 open_row;                 // Row held in the sense amps
    logic [WAIT_BITS-1:0] wait_cnt;                 // Cycles left before next command
    row_t                 req_row;
    logic                 row_hit;

    assign req_row = addr_row(req_q.addr);
    assign row_hit = (open_row == req_row);

    //----------------------------------------------------------
    // Next command for the held request
    //----------------------------------------------------------
    always_comb begin
        cmd.row   = req_row;
        cmd.col   = addr_col(req_q.addr);
        cmd.wdata = req_q.wdata;
        case (state)
            CLOSED: cmd.cmd = ACTIVATE;
            OPEN: begin
                if (!row_hit) begin
                    cmd.cmd = PRECHARGE;            // Row conflict, close first
                end else if (req_q.write) begin
                    cmd.cmd = WRITE;
                end else begin
                    cmd.cmd = READ;
                end
            end
            default: cmd.cmd = NOP;                 // Still timing out
        endcase
    end

    assign cmd_pending = busy && (wait_cnt == '0) && (state == CLOSED || state == OPEN);

    //----------------------------------------------------------
    // Bank state, occupancy and latency counter
    //----------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state    <= CLOSED;
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (load) begin
                busy <= 1'b1;
            end
            // Settle the transitional state as the counter expires
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
                if (wait_cnt == WAIT_BITS'(1)) begin
                    if (state == OPENING) begin
                        state <= OPEN;
                    end else begin
                        state <= CLOSED;
                    end
                end
            end
            if (grant) begin
                case (cmd.cmd)
                    ACTIVATE: begin
                        state    <= OPENING;
                        wait_cnt <= WAIT_BITS'(ACTIVATION_LATENCY - 1);
                    end
                    PRECHARGE: begin
                        state    <= CLOSING;
                        wait_cnt <= WAIT_BITS'(PRECHARGE_LATENCY - 1);
                    end
                    default: busy <= 1'b0;          // READ/WRITE ends the request, row stays open
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (load) req_q <= req;
        if (grant && cmd.cmd == ACTIVATE) open_row <= req_row;
    end

    a_load_idle: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        load |-> !busy);
    a_grant_pending: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        grant |-> cmd_pending);

endmodule : bank_machine

// File: hdl/command_arbiter.sv
//----------------------------------------------------------
// Round-robin command arbiter and DDR4 pin encoder
//----------------------------------------------------------
module command_arbiter import sdram_pkg::*; (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic [NUM_BANKS-1:0]  cmd_pending,
    input  bank_cmd_t             bank_cmds [NUM_BANKS],
    output logic [NUM_BANKS-1:0]  grant,
    output dram_pins_t            dram_pins,
    output logic [DATA_BITS-1:0]  dram_dq_out,
    output logic                  dram_dq_oe,
    output logic                  rd_issue,
    output logic [PADDR_BITS-1:0] rd_addr
);

    bank_id_t   last_q;                             // Most recently granted bank
    bank_id_t   win;
    logic       win_valid;
    bank_cmd_t  win_cmd;
    dram_pins_t pins_nxt;

    // ACTIVATE carries the row, everything else ras/cas/we on A16..A14
    function automatic dram_pins_t encode(dram_cmd_e op, bank_id_t bank, row_t row, col_t col);
        dram_pins_t p;
        logic [2:0] rcw;
        case (op)
            READ:      rcw = 3'b101;
            WRITE:     rcw = 3'b100;
            PRECHARGE: rcw = 3'b010;
            default:   rcw = 3'b111;                // NOP
        endcase
        p.bg = bank[BA_BITS +: BG_BITS];
        p.ba = bank[BA_BITS-1:0];
        if (op == ACTIVATE) begin
            p.act_n     = 1'b0;
            p.dram_addr = DRAM_ADDR_BITS'(row);     // Zero-padded row
        end else begin
            p.act_n     = 1'b1;
            p.dram_addr = {rcw, {(DRAM_ADDR_BITS-3-COL_BITS){1'b0}}, col};
        end
        return p;
    endfunction

    //----------------------------------------------------------
    // Search starts one past the last winner
    //----------------------------------------------------------
    always_comb begin
        bank_id_t idx;
        win       = last_q;
        win_valid = 1'b0;
        for (int i = 1; i <= NUM_BANKS; i++) begin
            idx = bank_id_t'(last_q + i);           // Wraps modulo NUM_BANKS
            if (!win_valid && cmd_pending[idx]) begin
                win_valid = 1'b1;
                win       = idx;
            end
        end
    end

    assign grant   = win_valid ? (NUM_BANKS'(1) << win) : '0;
    assign win_cmd = bank_cmds[win];

    always_comb begin
        if (win_valid) pins_nxt = encode(win_cmd.cmd, win, win_cmd.row, win_cmd.col);
        else           pins_nxt = encode(NOP, '0, '0, '0);
    end

    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            last_q     <= bank_id_t'(NUM_BANKS - 1);  // Bank 0 goes first
            dram_pins  <= encode(NOP, '0, '0, '0);
            dram_dq_oe <= 1'b0;
            rd_issue   <= 1'b0;
        end else begin
            if (win_valid) last_q <= win;
            dram_pins  <= pins_nxt;
            dram_dq_oe <= win_valid && (win_cmd.cmd == WRITE);  // Data beat with its WRITE
            rd_issue   <= win_valid && (win_cmd.cmd == READ);
        end
    end

    // Write beat and read tag aligned with the pins
    always_ff @(posedge clk_in) begin
        if (win_valid) begin
            dram_dq_out <= win_cmd.wdata;
            rd_addr     <= make_addr(win, win_cmd.row, win_cmd.col);
        end
    end

    // A pending bank always offers a real command
    a_win_cmd_real: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        win_valid |-> (win_cmd.cmd != NOP));

endmodule : command_arbiter

// File: hdl/read_return.sv
//----------------------------------------------------------
// Read return: CAS-latency tag pipeline and response register
//----------------------------------------------------------
module read_return import sdram_pkg::*; (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic                  rd_issue,
    input  logic [PADDR_BITS-1:0] rd_addr,
    input  logic [DATA_BITS-1:0]  dram_dq_in,
    output logic                  rsp_valid,
    output mem_rsp_t              rsp
);

    // Stage k holds a READ issued k+1 cycles ago
    logic [CAS_LATENCY-1:0]                 vld_sr;
    logic [CAS_LATENCY-1:0][PADDR_BITS-1:0] addr_sr;
    logic                                   data_due;   // dq carries this read's beat

    assign data_due = vld_sr[CAS_LATENCY-1];

    //----------------------------------------------------------
    // Valid flags, one slot per cycle so reads stay in order
    //----------------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            vld_sr    <= '0;
            rsp_valid <= 1'b0;
        end else begin
            vld_sr    <= {vld_sr[CAS_LATENCY-2:0], rd_issue};
            rsp_valid <= data_due;                  // CAS_LATENCY + 1 after the READ
        end
    end

    // Address tags travel beside the flags
    always_ff @(posedge clk_in) begin
        addr_sr <= {addr_sr[CAS_LATENCY-2:0], rd_addr};
        if (data_due) begin
            rsp.addr  <= addr_sr[CAS_LATENCY-1];
            rsp.rdata <= dram_dq_in;                // Sample the DIMM beat
        end
    end

endmodule : read_return

// File: hdl/sdram_controller.sv
//----------------------------------------------------------
// DDR4 SDRAM controller top: intake, bank machines, arbiter
//----------------------------------------------------------
module sdram_controller import sdram_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_N_in,
    // Requester side
    input  logic                 mem_req_valid,
    input  mem_req_t             mem_req,
    output logic                 mem_req_ack,
    output logic                 rsp_valid,
    output mem_rsp_t             rsp,
    // DIMM side
    output dram_pins_t           dram_pins,
    output logic [DATA_BITS-1:0] dram_dq_out,
    output logic                 dram_dq_oe,
    input  logic [DATA_BITS-1:0] dram_dq_in
);

    logic [NUM_BANKS-1:0]  bank_busy;
    logic [NUM_BANKS-1:0]  bank_load;
    mem_req_t              bank_req;                // Shared load bus
    logic [NUM_BANKS-1:0]  cmd_pending;
    bank_cmd_t             bank_cmds [NUM_BANKS];
    logic [NUM_BANKS-1:0]  grant;
    logic                  rd_issue;
    logic [PADDR_BITS-1:0] rd_addr;

    request_dispatch u_dispatch (
        .clk_in        (clk_in),
        .rst_N_in      (rst_N_in),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ack   (mem_req_ack),
        .bank_busy     (bank_busy),
        .bank_load     (bank_load),
        .bank_req      (bank_req)
    );

    // One machine per bank group / bank pair
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        bank_machine u_bank (
            .clk_in      (clk_in),
            .rst_N_in    (rst_N_in),
            .load        (bank_load[b]),
            .req         (bank_req),
            .busy        (bank_busy[b]),
            .cmd_pending (cmd_pending[b]),
            .cmd         (bank_cmds[b]),
            .grant       (grant[b])
        );
    end

    command_arbiter u_arbiter (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .cmd_pending (cmd_pending),
        .bank_cmds   (bank_cmds),
        .grant       (grant),
        .dram_pins   (dram_pins),
        .dram_dq_out (dram_dq_out),
        .dram_dq_oe  (dram_dq_oe),
        .rd_issue    (rd_issue),
        .rd_addr     (rd_addr)
    );

    read_return u_read_return (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .rd_issue   (rd_issue),
        .rd_addr    (rd_addr),
        .dram_dq_in (dram_dq_in),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule : sdram_controller

// File: verification/clock_gen.sv
//----------------------------------------------------------
// Testbench clock and power-on reset source
//----------------------------------------------------------
module clock_gen (
    output logic clk_in,
    output logic rst_N_in
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;                // 10 ns clock
    localparam int RESET_CYCLES = 16;

    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    // Release away from the active edge
    initial begin
        rst_N_in = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_in);
        @(negedge clk_in);
        rst_N_in = 1'b1;
    end

endmodule : clock_gen

// File: verification/tb_sdram_controller.sv
//----------------------------------------------------------
// DDR4 controller testbench with random requests and a DIMM model
// Checks command legality, open-page policy and read returns
//----------------------------------------------------------
module tb_sdram_controller import sdram_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQUESTS    = 300;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS *
        (PRECHARGE_LATENCY + ACTIVATION_LATENCY + CAS_LATENCY + 40);

    logic                 clk_in, rst_N_in;
    logic                 mem_req_valid, mem_req_ack, rsp_valid, dram_dq_oe;
    mem_req_t             mem_req;
    mem_rsp_t             rsp;
    dram_pins_t           dram_pins;
    logic [DATA_BITS-1:0] dram_dq_out, dram_dq_in;

    logic [31:0] lfsr_state = 32'h2b53_240d;
    int          cycle;                             // Posedge count with one observation each
    int          accept_count, access_count, rsp_count;
    logic        ack_q, req_q, req_fell_q;          // Handshake as seen at the last edge

    // Per-bank DIMM state and the single request each bank may hold
    logic                  bank_open [NUM_BANKS];
    row_t                  open_row [NUM_BANKS];
    int                    pre_cycle [NUM_BANKS], act_cycle [NUM_BANKS];
    int                    pre_count [NUM_BANKS], act_count [NUM_BANKS];
    logic                  had_access [NUM_BANKS];
    row_t                  last_row [NUM_BANKS];
    logic                  slot_valid [NUM_BANKS], slot_write [NUM_BANKS];
    logic [PADDR_BITS-1:0] slot_addr [NUM_BANKS];
    logic [DATA_BITS-1:0]  slot_wdata [NUM_BANKS], slot_rdata [NUM_BANKS];

    logic [DATA_BITS-1:0]  ref_mem [logic [PADDR_BITS-1:0]];   // Request-order memory
    logic [DATA_BITS-1:0]  dimm_mem [logic [PADDR_BITS-1:0]];  // Pin-order memory
    int                    dq_due_q[$], rsp_due_q[$];
    logic [DATA_BITS-1:0]  dq_data_q[$], rsp_data_q[$];
    logic [PADDR_BITS-1:0] rsp_addr_q[$];

    clock_gen clock_gen0 (.clk_in(clk_in), .rst_N_in(rst_N_in));

    sdram_controller dut0 (
        .clk_in        (clk_in),
        .rst_N_in      (rst_N_in),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ack   (mem_req_ack),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .dram_pins     (dram_pins),
        .dram_dq_out   (dram_dq_out),
        .dram_dq_oe    (dram_dq_oe),
        .dram_dq_in    (dram_dq_in)
    );

    //----------------------------------------------------------
    // Failure reporting and random source
    //----------------------------------------------------------
    task automatic stop_with_failure();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic fail_run(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_with_failure();
    endtask

    task automatic flag_mismatch(input string sig, input logic [63:0] exp, input logic [63:0] act);
        $display("Mismatch at %0t: %s expected %h actual %h", $time, sig, exp, act);
        stop_with_failure();
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] draw_bits(int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic row_t pick_row(logic [1:0] sel);
        case (sel)                                  // Few rows so hits and conflicts are common
            2'd0:    return 8'h00;
            2'd1:    return 8'h3c;
            2'd2:    return 8'h96;
            default: return 8'hf1;
        endcase
    endfunction

    function automatic logic [DATA_BITS-1:0] unwritten_word(logic [PADDR_BITS-1:0] addr);
        return {4{addr}};
    endfunction

    //----------------------------------------------------------
    // Command checks against the per-bank model
    //----------------------------------------------------------
    task automatic check_activate(input bank_id_t bank, input row_t row);
        assert (!bank_open[bank]) else fail_run($sformatf("ACTIVATE on open bank %0d", bank));
        assert (cycle - pre_cycle[bank] >= PRECHARGE_LATENCY)
            else fail_run($sformatf("ACTIVATE too soon after PRECHARGE on bank %0d", bank));
        assert (dram_pins.dram_addr[DRAM_ADDR_BITS-1:ROW_BITS] == '0)
            else flag_mismatch("dram_addr high bits", 0, dram_pins.dram_addr);
        bank_open[bank] = 1'b1;
        open_row[bank]  = row;
        act_cycle[bank] = cycle;
        act_count[bank]++;
    endtask

    task automatic check_precharge(input bank_id_t bank);
        assert (bank_open[bank]) else fail_run($sformatf("PRECHARGE on closed bank %0d", bank));
        bank_open[bank] = 1'b0;
        pre_cycle[bank] = cycle;
        pre_count[bank]++;
    endtask

    task automatic check_access(input bank_id_t bank, input row_t row, input col_t col,
                                input logic is_write);
        logic [PADDR_BITS-1:0] addr;
        int                    exp_pre, exp_act;
        addr = {row, bank, col};
        assert (bank_open[bank])
            else fail_run($sformatf("READ/WRITE on bank %0d without its row open", bank));
        assert (cycle - act_cycle[bank] >= ACTIVATION_LATENCY)
            else fail_run($sformatf("READ/WRITE too soon after ACTIVATE on bank %0d", bank));
        assert (slot_valid[bank] === 1'b1)
            else fail_run($sformatf("READ/WRITE on bank %0d with no request held", bank));
        // Open row must be the requested one
        assert (addr == slot_addr[bank])
            else flag_mismatch("access address", slot_addr[bank], addr);
        assert (is_write == slot_write[bank])
            else flag_mismatch("access write", slot_write[bank], is_write);
        // Open page means a hit needs no row commands and a conflict exactly one of each
        exp_pre = (had_access[bank] && last_row[bank] != row) ? 1 : 0;
        exp_act = (had_access[bank] && last_row[bank] == row) ? 0 : 1;
        assert (pre_count[bank] == exp_pre)
            else flag_mismatch("PRECHARGE count", exp_pre, pre_count[bank]);
        assert (act_count[bank] == exp_act)
            else flag_mismatch("ACTIVATE count", exp_act, act_count[bank]);
        if (is_write) begin
            assert (dram_dq_oe) else fail_run("dram_dq_oe low during a WRITE");
            assert (dram_dq_out == slot_wdata[bank])
                else flag_mismatch("dram_dq_out", slot_wdata[bank], dram_dq_out);
            dimm_mem[addr] = dram_dq_out;
        end else begin
            dq_due_q.push_back(cycle + CAS_LATENCY - 1);    // Driven in cycle READ + CL
            dq_data_q.push_back(dimm_mem.exists(addr) ? dimm_mem[addr] : unwritten_word(addr));
            rsp_due_q.push_back(cycle + CAS_LATENCY + 1);
            rsp_addr_q.push_back(addr);
            rsp_data_q.push_back(slot_rdata[bank]);
        end
        had_access[bank] = 1'b1;
        last_row[bank]   = row;
        pre_count[bank]  = 0;
        act_count[bank]  = 0;
        slot_valid[bank] = 1'b0;
        access_count++;
    endtask

    task automatic check_response();
        if (rsp_due_q.size() > 0 && rsp_due_q[0] == cycle) begin
            assert (rsp_valid)
                else fail_run("rsp_valid missing CAS_LATENCY + 1 cycles after READ");
            assert (rsp.addr == rsp_addr_q[0])
                else flag_mismatch("rsp.addr", rsp_addr_q[0], rsp.addr);
            assert (rsp.rdata == rsp_data_q[0])
                else flag_mismatch("rsp.rdata", rsp_data_q[0], rsp.rdata);
            void'(rsp_due_q.pop_front());
            void'(rsp_addr_q.pop_front());
            void'(rsp_data_q.pop_front());
            rsp_count++;
        end else begin
            assert (!rsp_valid) else fail_run("rsp_valid high with no READ due");
        end
    endtask

    task automatic accept_request();
        bank_id_t bank;
        bank = mem_req.addr[COL_BITS +: BG_BITS+BA_BITS];
        assert (slot_valid[bank] !== 1'b1)
            else fail_run($sformatf("request accepted while bank %0d still holds one", bank));
        slot_valid[bank] = 1'b1;
        slot_addr[bank]  = mem_req.addr;
        slot_write[bank] = mem_req.write;
        slot_wdata[bank] = mem_req.wdata;
        slot_rdata[bank] = ref_mem.exists(mem_req.addr) ? ref_mem[mem_req.addr]
                                                        : unwritten_word(mem_req.addr);
        if (mem_req.write) ref_mem[mem_req.addr] = mem_req.wdata;
        accept_count++;
    endtask

    //----------------------------------------------------------
    // Monitor where values seen at an edge belong to the cycle it closes
    //----------------------------------------------------------
    always @(posedge clk_in) begin
        logic [2:0] rcw;
        bank_id_t   bank;
        col_t       col;
        rcw  = dram_pins.dram_addr[DRAM_ADDR_BITS-1 -: 3];
        bank = {dram_pins.bg, dram_pins.ba};
        col  = dram_pins.dram_addr[COL_BITS-1:0];
        cycle++;
        if (!rst_N_in) begin
            if (cycle > 1) begin                    // First edge applies the reset
                assert (!mem_req_ack && !rsp_valid && !dram_dq_oe)
                    else fail_run("ack, rsp_valid or dram_dq_oe high during reset");
                assert (dram_pins.act_n && rcw == 3'b111)
                    else fail_run("pins not NOP during reset");
            end
        end else begin
            if (!dram_pins.act_n) begin
                check_activate(bank, dram_pins.dram_addr[ROW_BITS-1:0]);
            end else begin
                case (rcw)
                    3'b101:  check_access(bank, open_row[bank], col, 1'b0);
                    3'b100:  check_access(bank, open_row[bank], col, 1'b1);
                    3'b010:  check_precharge(bank);
                    3'b111:  ;                      // NOP
                    default: fail_run("unknown ras/cas/we code on the pins");
                endcase
            end
            if (!(dram_pins.act_n && rcw == 3'b100)) begin
                assert (!dram_dq_oe) else fail_run("dram_dq_oe high outside a WRITE");
            end
            check_response();
            if (mem_req_ack && !ack_q) begin
                assert (req_q) else fail_run("mem_req_ack rose with no request raised");
                accept_request();
            end
            if (req_fell_q) begin
                assert (!mem_req_ack) else fail_run("mem_req_ack still high a cycle after req fell");
            end
            if (ack_q && !mem_req_ack) begin
                assert (req_fell_q) else fail_run("mem_req_ack fell without req falling first");
            end
            req_fell_q = req_q && !mem_req_valid;
            ack_q      = mem_req_ack;
            req_q      = mem_req_valid;
        end
    end

    // DIMM read data driven mid-cycle for the DUT's sampling edge
    always @(negedge clk_in) begin
        if (dq_due_q.size() > 0 && dq_due_q[0] == cycle) begin
            dram_dq_in = dq_data_q.pop_front();
            void'(dq_due_q.pop_front());
        end else begin
            dram_dq_in = '0;
        end
    end

    //----------------------------------------------------------
    // Four-phase requester driving on the falling edge
    //----------------------------------------------------------
    initial begin
        logic [1:0] row_sel;
        bank_id_t   bank;
        col_t       col;
        int         gap;
        mem_req_valid = 1'b0;
        mem_req       = '0;
        dram_dq_in    = '0;
        {ack_q, req_q, req_fell_q} = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_open[b]  = 1'b0;
            had_access[b] = 1'b0;
            slot_valid[b] = 1'b0;
        end
        @(posedge rst_N_in);
        for (int i = 0; i < NUM_REQUESTS; i++) begin
            gap = int'(draw_bits(3));
            repeat (gap) @(negedge clk_in);
            @(negedge clk_in);
            row_sel       = draw_bits(2);
            bank          = draw_bits(4);
            col           = draw_bits(4);
            mem_req.addr  = {pick_row(row_sel), bank, col};
            mem_req.write = (draw_bits(5) < 13);    // About 40 percent stores
            mem_req.wdata = draw_bits(64);
            mem_req_valid = 1'b1;
            do @(negedge clk_in); while (!mem_req_ack);
            mem_req_valid = 1'b0;
            do @(negedge clk_in); while (mem_req_ack);
        end
        // Every accepted request must reach the pins and every READ must return
        while (access_count != accept_count || rsp_due_q.size() != 0) @(negedge clk_in);
        $display("Completed %0d requests, %0d reads returned", accept_count, rsp_count);
        $display("STATUS: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        fail_run("watchdog expired before all requests completed");
    end

endmodule : tb_sdram_controller

// File: sources.f
hdl/sdram_pkg.sv
hdl/request_dispatch.sv
hdl/bank_machine.sv
hdl/command_arbiter.sv
hdl/read_return.sv
hdl/sdram_controller.sv
verification/clock_gen.sv
verification/tb_sdram_controller.sv
